// File: tb.f
+incdir+.
ngram_pkg.sv
win_if.sv
agu_next.sv
cmd_decode.sv
exe_ctrl.sv
window_datapath.sv
result_serializer.sv
ngram_top.sv
tb_ngram.sv

// File: Bender.yml
package:
  name: ngram

sources:
  - include_dirs:
      - .
    files:
      - ngram_pkg.sv
      - win_if.sv
      - agu_next.sv
      - cmd_decode.sv
      - exe_ctrl.sv
      - window_datapath.sv
      - result_serializer.sv
      - ngram_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ngram.sv

// File: tb_ngram.sv
`timescale 1ns/1ps
`include "ngram_params.svh"

module tb_ngram
    import ngram_pkg::*;
();

    // samples of all tests, sized for the watchdog
    localparam int TOTAL_SAMPLES = 1 + 20 + 64 + 64 + 4 * 1056 + 30 + 10;
    localparam int WATCHDOG_CYC  = TOTAL_SAMPLES * 20 + 5000;

    logic      clk;
    logic      rst;
    logic      src_we_i;
    src_addr_t src_addr_i;
    src_data_t src_data_i;
    logic      start_i;
    count_t    win_count_i;
    count_t    win_len_i;
    logic      busy_o;
    logic      done_o;
    logic      cmd_err_o;
    logic      dst_valid_o;
    beat_t     dst_data_o;
    logic      dst_last_o;

    // host copy of the source buffer
    src_data_t src_model [`NGRAM_SRC_DEPTH];
    win_sum_t  got_sums [$];
    logic      got_last [$];
    win_sum_t  cur_sum;
    int        beat_idx;
    int        beat_cnt;
    int        last_cnt;
    int        done_cnt;
    int        err_cnt;
    int        errors;
    int        checks;
    integer    seed;
    // counter snapshots taken at job start
    int        beat0;
    int        last0;
    int        done0;
    int        err0;

    ngram_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .src_we_i    (src_we_i),
        .src_addr_i  (src_addr_i),
        .src_data_i  (src_data_i),
        .start_i     (start_i),
        .win_count_i (win_count_i),
        .win_len_i   (win_len_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .cmd_err_o   (cmd_err_o),
        .dst_valid_o (dst_valid_o),
        .dst_data_o  (dst_data_o),
        .dst_last_o  (dst_last_o)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // output monitor, samples on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            if (dst_valid_o) begin
                // beats arrive lowest byte first
                cur_sum[beat_idx*`NGRAM_BEAT_W +: `NGRAM_BEAT_W] = dst_data_o;
                beat_cnt++;
                if (dst_last_o) last_cnt++;
                if (beat_idx == `NGRAM_BEATS - 1) begin
                    got_sums.push_back(cur_sum);
                    got_last.push_back(dst_last_o);
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
            end
            if (done_o) done_cnt++;
            if (cmd_err_o) err_cnt++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare helpers and reference model
    //////////////////////////////////////////////////////////////////////

    task automatic check_sum(input win_sum_t got, input win_sum_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED @ %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED @ %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string msg);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED @ %0t: %s got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    // samples w .. w+len-1, wraps at 2^32
    function automatic win_sum_t expected_sum(input int w, input int len);
        win_sum_t s;
        s = '0;
        for (int k = 0; k < len; k++) begin
            s = s + win_sum_t'(src_model[w + k]);
        end
        return s;
    endfunction

    task automatic write_buffer(input bit use_random);
        src_data_t d;
        for (int a = 0; a < `NGRAM_SRC_DEPTH; a++) begin
            if (use_random) d = src_data_t'($random(seed));
            else d = {a[5:0], 2'b11} ^ 8'h5a;
            @(posedge clk);
            src_we_i   <= 1'b1;
            src_addr_i <= src_addr_t'(a);
            src_data_i <= d;
            src_model[a] = d;
        end
        @(posedge clk);
        src_we_i <= 1'b0;
    endtask

    task automatic issue_start(input int cnt, input int len);
        @(posedge clk);
        start_i     <= 1'b1;
        win_count_i <= count_t'(cnt);
        win_len_i   <= count_t'(len);
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic begin_job(input int cnt, input int len);
        got_sums.delete();
        got_last.delete();
        beat0 = beat_cnt;
        last0 = last_cnt;
        done0 = done_cnt;
        err0  = err_cnt;
        issue_start(cnt, len);
    endtask

    task automatic end_job(input int cnt, input int len, input int exp_err);
        int limit;
        int cyc;
        limit = cnt * (len + 12) + 100;
        cyc   = 0;
        while (done_cnt == done0 && cyc < limit) begin
            @(posedge clk);
            cyc++;
        end
        if (done_cnt == done0) begin
            errors++;
            $display("timeout: done_o never pulsed for count %0d length %0d", cnt, len);
        end
        // quiet window, nothing more may come out
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_count(got_sums.size(), cnt, "window count");
        check_count(beat_cnt - beat0, cnt * `NGRAM_BEATS, "beat count");
        check_count(beat_idx, 0, "partial window");
        for (int w = 0; w < cnt && w < got_sums.size(); w++) begin
            check_sum(got_sums[w], expected_sum(w, len), $sformatf("window %0d sum", w));
            check_flag(got_last[w], w == cnt - 1, $sformatf("window %0d last", w));
        end
        check_count(last_cnt - last0, 1, "dst_last_o pulses");
        check_count(done_cnt - done0, 1, "done_o pulses");
        check_count(err_cnt - err0, exp_err, "cmd_err_o pulses");
        check_flag(busy_o, 1'b0, "busy_o after done");
    endtask

    // rejected command, one error pulse and no output at all
    task automatic reject_job(input int cnt, input int len);
        begin_job(cnt, len);
        repeat (30) @(posedge clk);
        @(negedge clk);
        check_count(err_cnt - err0, 1, "cmd_err_o on bad start");
        check_count(beat_cnt - beat0, 0, "beats on bad start");
        check_count(done_cnt - done0, 0, "done_o on bad start");
        check_flag(busy_o, 1'b0, "busy_o on bad start");
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_single;
        write_buffer(1'b0);
        begin_job(1, 1);
        end_job(1, 1, 0);
    endtask

    task automatic test_overlap;
        write_buffer(1'b0);
        begin_job(5, 4);
        end_job(5, 4, 0);
        // full-buffer extremes
        begin_job(1, 64);
        end_job(1, 64, 0);
        begin_job(64, 1);
        end_job(64, 1, 0);
    endtask

    task automatic test_random;
        int len;
        int cnt;
        for (int n = 0; n < 4; n++) begin
            write_buffer(1'b1);
            len = 1 + ($unsigned($random(seed)) % 64);
            cnt = 1 + ($unsigned($random(seed)) % (65 - len));
            begin_job(cnt, len);
            end_job(cnt, len, 0);
        end
    endtask

    task automatic test_bad_cmd;
        reject_job(0, 4);
        reject_job(4, 0);
        reject_job(33, 33);
    endtask

    task automatic test_start_busy;
        write_buffer(1'b1);
        begin_job(6, 5);
        @(negedge clk);
        check_flag(busy_o, 1'b1, "busy_o during run");
        // second start lands while the first run is active
        issue_start(2, 2);
        end_job(6, 5, 1);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        src_we_i    = 1'b0;
        src_addr_i  = '0;
        src_data_i  = '0;
        start_i     = 1'b0;
        win_count_i = '0;
        win_len_i   = '0;
        cur_sum     = '0;
        beat_idx    = 0;
        beat_cnt    = 0;
        last_cnt    = 0;
        done_cnt    = 0;
        err_cnt     = 0;
        errors      = 0;
        checks      = 0;
        seed        = 32'hfff2cf32;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_single();
        test_overlap();
        test_random();
        test_bad_cmd();
        test_start_busy();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYC * 10);
        $display("watchdog expired, the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: ngram_top.sv
`timescale 1ns/1ps

module ngram_top
    import ngram_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      src_we_i,
    input  src_addr_t src_addr_i,
    input  src_data_t src_data_i,
    input  logic      start_i,
    input  count_t    win_count_i,
    input  count_t    win_len_i,
    output logic      busy_o,
    output logic      done_o,
    output logic      cmd_err_o,
    output logic      dst_valid_o,
    output beat_t     dst_data_o,
    output logic      dst_last_o
);

    logic      s_init;
    src_addr_t fin_i;
    src_addr_t fin_j;
    logic      k_init;
    logic      exec;
    logic      k_fin;
    src_addr_t idx_i;
    src_addr_t idx_j;

    win_if u_win ();

    // decode
    cmd_decode u_dec (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .win_count_i (win_count_i),
        .win_len_i   (win_len_i),
        .s_fin_i     (done_o),
        .s_init_o    (s_init),
        .fin_i_o     (fin_i),
        .fin_j_o     (fin_j),
        .busy_o      (busy_o),
        .cmd_err_o   (cmd_err_o)
    );

    // execute, sequencer
    exe_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .s_init_i (s_init),
        .fin_i_i  (fin_i),
        .fin_j_i  (fin_j),
        .win      (u_win.ctrl),
        .k_init_o (k_init),
        .exec_o   (exec),
        .k_fin_o  (k_fin),
        .i_o      (idx_i),
        .j_o      (idx_j),
        .s_fin_o  (done_o)
    );

    // execute, buffer and accumulator
    window_datapath u_dp (
        .clk        (clk),
        .rst        (rst),
        .src_we_i   (src_we_i),
        .src_addr_i (src_addr_i),
        .src_data_i (src_data_i),
        .k_init_i   (k_init),
        .exec_i     (exec),
        .k_fin_i    (k_fin),
        .i_i        (idx_i),
        .j_i        (idx_j),
        .win        (u_win.dp)
    );

    // result
    result_serializer u_ser (
        .clk         (clk),
        .rst         (rst),
        .win         (u_win.res),
        .dst_valid_o (dst_valid_o),
        .dst_data_o  (dst_data_o),
        .dst_last_o  (dst_last_o)
    );

endmodule

// File: result_serializer.sv
`timescale 1ns/1ps
`include "ngram_params.svh"

module result_serializer
    import ngram_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    win_if.res    win,
    output logic  dst_valid_o,
    output beat_t dst_data_o,
    output logic  dst_last_o
);

    localparam int unsigned CNT_W = $clog2(`NGRAM_BEATS);

    ser_state_t       state_q;
    logic [CNT_W-1:0] beat_q;
    win_sum_t         sreg_q;
    logic             final_beat;

    assign final_beat = (state_q == SER_SHIFT) &&
                        (beat_q == CNT_W'(`NGRAM_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= SER_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    if (win.win_valid) begin
                        state_q <= SER_SHIFT;
                        beat_q  <= '0;
                    end
                end
                SER_SHIFT: begin
                    beat_q <= beat_q + CNT_W'(1);
                    if (final_beat) state_q <= SER_IDLE;
                end
                default: state_q <= SER_IDLE;
            endcase
        end
    end

    // lowest byte leaves first
    always_ff @(posedge clk) begin
        if (state_q == SER_IDLE && win.win_valid) begin
            sreg_q <= win.win_sum;
        end else if (state_q == SER_SHIFT) begin
            sreg_q <= sreg_q >> `NGRAM_BEAT_W;
        end
    end

    assign dst_valid_o = (state_q == SER_SHIFT);
    assign dst_data_o  = sreg_q[`NGRAM_BEAT_W-1:0];
    // win_last still high on the final beat of the last window only
    assign dst_last_o  = final_beat & win.win_last;
    assign win.out_fin = final_beat & win.win_last;
    // busy from win_valid itself, closes the launch window in exe_ctrl
    assign win.out_busy = win.win_valid | (state_q == SER_SHIFT);

    // a window may only finish once the previous one has drained
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        win.win_valid |-> state_q == SER_IDLE);

endmodule

// File: window_datapath.sv
`timescale 1ns/1ps
`include "ngram_params.svh"

module window_datapath
    import ngram_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      src_we_i,
    input  src_addr_t src_addr_i,
    input  src_data_t src_data_i,
    input  logic      k_init_i,
    input  logic      exec_i,
    input  logic      k_fin_i,
    input  src_addr_t i_i,
    input  src_addr_t j_i,
    win_if.dp         win
);

    src_data_t mem [`NGRAM_SRC_DEPTH];
    src_addr_t rd_addr;
    src_data_t rd_data_q;
    logic      rd_vld_q;
    win_sum_t  acc_q;
    logic      valid_q;

    // host write port
    always_ff @(posedge clk) begin
        if (src_we_i) begin
            mem[src_addr_i] <= src_data_i;
        end
    end

    // stride 1, i + j never passes the last entry
    assign rd_addr = i_i + j_i;

    always_ff @(posedge clk) begin
        if (exec_i) begin
            rd_data_q <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            rd_vld_q <= exec_i;
            // last add lands in the k_fin cycle
            valid_q  <= k_fin_i;
        end
    end

    // unsigned samples, zero extended
    always_ff @(posedge clk) begin
        if (k_init_i) begin
            acc_q <= '0;
        end else if (rd_vld_q) begin
            acc_q <= acc_q + win_sum_t'(rd_data_q);
        end
    end

    // acc stays put until the next k_init
    assign win.win_valid = valid_q;
    assign win.win_sum   = acc_q;

endmodule

// File: exe_ctrl.sv
`timescale 1ns/1ps
`include "ngram_params.svh"

module exe_ctrl
    import ngram_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      s_init_i,
    input  src_addr_t fin_i_i,
    input  src_addr_t fin_j_i,
    win_if.ctrl       win,
    output logic      k_init_o,
    output logic      exec_o,
    output logic      k_fin_o,
    output src_addr_t i_o,
    output src_addr_t j_o,
    output logic      s_fin_o
);

    logic last_i;
    logic next_i;
    logic last_j;
    logic next_d;
    logic k_pend_q;
    logic win_last_q;

    //////////////////////////////////////////////////////////////////////
    // window launch
    //////////////////////////////////////////////////////////////////////

    // next_i delayed once, so the pending window is seen no earlier
    // than win_valid, when out_busy is already up
    always_ff @(posedge clk) begin
        if (rst) begin
            next_d   <= 1'b0;
            k_pend_q <= 1'b0;
        end else begin
            next_d   <= next_i;
            // first window from s_init, the rest from the outer counter
            k_pend_q <= (k_pend_q | s_init_i | next_d) & ~k_init_o;
        end
    end

    // held back while the serializer drains
    assign k_init_o = k_pend_q & ~win.out_busy;

    //////////////////////////////////////////////////////////////////////
    // loops
    //////////////////////////////////////////////////////////////////////

    // outer loop over windows, steps once per finished window
    agu_next #(.W(`NGRAM_ADDR_W)) l_i (
        .clk     (clk),
        .rst     (rst),
        .start_i (s_init_i),
        .en_i    (last_j),
        .fin_i   (fin_i_i),
        .data_o  (i_o),
        .last_o  (last_i),
        .next_o  (next_i)
    );

    // inner loop over samples, one per exec cycle
    agu_next #(.W(`NGRAM_ADDR_W)) l_j (
        .clk     (clk),
        .rst     (rst),
        .start_i (k_init_o),
        .en_i    (exec_o),
        .fin_i   (fin_j_i),
        .data_o  (j_o),
        .last_o  (last_j),
        .next_o  ()
    );

    // exec from the cycle after k_init through last_j
    always_ff @(posedge clk) begin
        if (rst) begin
            exec_o  <= 1'b0;
            k_fin_o <= 1'b0;
        end else begin
            exec_o  <= k_init_o | (exec_o & ~last_j);
            k_fin_o <= last_j;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // run end
    //////////////////////////////////////////////////////////////////////

    // set by the last window, dropped with the final beat
    always_ff @(posedge clk) begin
        if (rst) begin
            win_last_q <= 1'b0;
            s_fin_o    <= 1'b0;
        end else begin
            if (last_i) begin
                win_last_q <= 1'b1;
            end else if (win.out_fin) begin
                win_last_q <= 1'b0;
            end
            s_fin_o <= win_last_q & win.out_fin;
        end
    end

    assign win.win_last = win_last_q;

    // no launch over a window still running or closing
    a_kinit_idle: assert property (@(posedge clk) disable iff (rst)
        k_init_o |-> !exec_o && !k_fin_o);

    // run end only once all windows are computed
    a_exec_sfin: assert property (@(posedge clk) disable iff (rst)
        !(exec_o && s_fin_o));

endmodule

// File: cmd_decode.sv
`timescale 1ns/1ps
`include "ngram_params.svh"

module cmd_decode
    import ngram_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  count_t    win_count_i,
    input  count_t    win_len_i,
    input  logic      s_fin_i,
    output logic      s_init_o,
    output src_addr_t fin_i_o,
    output src_addr_t fin_j_o,
    output logic      busy_o,
    output logic      cmd_err_o
);

    dec_state_t                state_q;
    logic [`NGRAM_ADDR_W+1:0]  span;
    count_t                    cnt_m1;
    count_t                    len_m1;
    logic                      cmd_ok;
    logic                      accept;

    // last address touched is count + len - 2, must stay inside the buffer
    assign span   = {1'b0, win_count_i} + {1'b0, win_len_i};
    assign cmd_ok = (win_count_i != '0) && (win_len_i != '0) &&
                    (span <= (`NGRAM_SRC_DEPTH + 1));
    assign accept = (state_q == DEC_IDLE) && start_i && cmd_ok;

    // loop bounds are inclusive
    assign cnt_m1 = win_count_i - count_t'(1);
    assign len_m1 = win_len_i - count_t'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= DEC_IDLE;
            s_init_o  <= 1'b0;
            cmd_err_o <= 1'b0;
        end else begin
            s_init_o  <= accept;
            // bad bounds, or a start on top of a running job
            cmd_err_o <= start_i & ~accept;
            case (state_q)
                DEC_IDLE: if (accept) state_q <= DEC_RUN;
                DEC_RUN:  if (s_fin_i) state_q <= DEC_IDLE;
                default:  state_q <= DEC_IDLE;
            endcase
        end
    end

    // bounds held for the whole run
    always_ff @(posedge clk) begin
        if (accept) begin
            fin_i_o <= cnt_m1[`NGRAM_ADDR_W-1:0];
            fin_j_o <= len_m1[`NGRAM_ADDR_W-1:0];
        end
    end

    assign busy_o = (state_q == DEC_RUN);

endmodule

// File: agu_next.sv
`timescale 1ns/1ps

module agu_next #(
    parameter int unsigned W = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start_i,
    input  logic         en_i,
    input  logic [W-1:0] fin_i,
    output logic [W-1:0] data_o,
    output logic         last_o,
    output logic         next_o
);

    logic armed_q;
    logic step;
    logic at_end;

    // a step only counts while armed
    assign step   = armed_q & en_i;
    assign at_end = (data_o == fin_i);

    // last on the final index, next on every other step
    assign last_o = step & at_end;
    assign next_o = step & ~at_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            armed_q <= 1'b0;
            data_o  <= '0;
        end else if (start_i) begin
            // restart from zero, even mid-count
            armed_q <= 1'b1;
            data_o  <= '0;
        end else if (step) begin
            if (at_end) begin
                // hold the final index, wait for the next start
                armed_q <= 1'b0;
            end else begin
                data_o <= data_o + W'(1);
            end
        end
    end

endmodule

// File: win_if.sv
`timescale 1ns/1ps

interface win_if
    import ngram_pkg::*;
();

    // one pulse per finished window, sum held with it
    logic     win_valid;
    win_sum_t win_sum;
    // high once the outer loop issued its last window
    logic     win_last;
    // serializer side, busy level and end-of-run pulse
    logic     out_busy;
    logic     out_fin;

    modport dp   (output win_valid, output win_sum);
    modport ctrl (output win_last, input out_busy, input out_fin);
    modport res  (input win_valid, input win_sum, input win_last,
                  output out_busy, output out_fin);

endinterface

// File: ngram_pkg.sv
`include "ngram_params.svh"

package ngram_pkg;

    // buffer address, doubles as loop index
    typedef logic [`NGRAM_ADDR_W-1:0] src_addr_t;
    typedef logic [`NGRAM_SRC_W-1:0]  src_data_t;
    // host count or length, 1..depth, so one bit wider than an address
    typedef logic [`NGRAM_ADDR_W:0]   count_t;
    typedef logic [`NGRAM_SUM_W-1:0]  win_sum_t;
    typedef logic [`NGRAM_BEAT_W-1:0] beat_t;

    // command decoder
    typedef enum logic {
        DEC_IDLE,
        DEC_RUN
    } dec_state_t;

    // byte serializer
    typedef enum logic {
        SER_IDLE,
        SER_SHIFT
    } ser_state_t;

endpackage

// File: ngram_params.svh
`ifndef NGRAM_PARAMS_SVH
`define NGRAM_PARAMS_SVH

// source buffer geometry
`define NGRAM_SRC_DEPTH 64
`define NGRAM_ADDR_W    6
`define NGRAM_SRC_W     8

// result path
`define NGRAM_SUM_W     32
`define NGRAM_BEAT_W    8
// beats per sum, SUM_W / BEAT_W
`define NGRAM_BEATS     4

`endif
